// File: design/periph_pkg.sv
package periph_pkg;

    localparam int XLEN = 64; // bus data and address width

    // address map
    localparam logic [63:0] RAM_BASE      = 64'h8000_0000;
    localparam int          RAM_WORDS     = 1024;
    localparam int          RAM_AW        = 10; // word index width
    localparam logic [63:0] RAM_BYTES     = 64'(RAM_WORDS * 4);
    localparam logic [63:0] MTIMECMP_ADDR = 64'h0200_4000;
    localparam logic [63:0] PLIC_BASE     = 64'h0C00_0000; // priority n at base + 4n

    // offsets inside the plic window
    localparam logic [15:0] PLIC_PENDING_OFS       = 16'h1000;
    localparam logic [15:0] PLIC_ENABLE_OFS        = 16'h2000;
    localparam logic [15:0] PLIC_CTX_ENABLE_STRIDE = 16'h80;
    localparam logic [23:0] PLIC_THRESHOLD_OFS     = 24'h20_0000;
    localparam logic [15:0] PLIC_CTX_STRIDE        = 16'h1000;
    localparam logic [23:0] PLIC_CLAIM_OFS         = 24'h20_0004;
    localparam logic [23:0] PLIC_SPAN              = 24'h40_0000;

    // interrupt sources, id 0 is reserved for "none"
    localparam int IRQ_SOURCES = 6;
    localparam int IRQ_ID_W    = 3;
    localparam int PRIO_W      = 3;

    localparam logic [63:0] MTIMECMP_RESET = 64'h8000_0000;

    // load/store size, bit 2 marks unsigned loads
    typedef enum logic [2:0] {
        LS_B  = 3'd0,
        LS_H  = 3'd1,
        LS_W  = 3'd2,
        LS_D  = 3'd3,
        LS_BU = 3'd4,
        LS_HU = 3'd5,
        LS_WU = 3'd6
    } ls_type_e;

    // decoded target of a bus access
    typedef enum logic [1:0] {
        REG_NONE,
        REG_RAM,
        REG_MTIMECMP,
        REG_PLIC
    } region_e;

endpackage

// File: design/periph_bus_if.sv
`timescale 1ns/1ps

interface periph_bus_if;

    logic                         req_valid;   // one-cycle strobe
    logic                         req_write;
    periph_pkg::ls_type_e         req_ls_type;
    logic [periph_pkg::XLEN-1:0]  req_offset;  // address minus region base
    logic [periph_pkg::XLEN-1:0]  req_wdata;
    logic                         ack;         // one cycle, once per request
    logic [periph_pkg::XLEN-1:0]  rdata;       // valid with ack

    modport sequencer (
        output req_valid,
        output req_write,
        output req_ls_type,
        output req_offset,
        output req_wdata,
        input  ack,
        input  rdata
    );

    modport target (
        input  req_valid,
        input  req_write,
        input  req_ls_type,
        input  req_offset,
        input  req_wdata,
        output ack,
        output rdata
    );

endinterface

// File: design/bus_sequencer.sv
`timescale 1ns/1ps

module bus_sequencer (
    input  logic                        CLOCK_50,
    input  logic                        KEY0,
    input  logic [periph_pkg::XLEN-1:0] bus_address,
    input  logic [periph_pkg::XLEN-1:0] bus_write_data,
    input  periph_pkg::ls_type_e        bus_ls_type,
    input  logic                        bus_read_enable,
    input  logic                        bus_write_enable,
    output logic [periph_pkg::XLEN-1:0] bus_read_data,
    output logic                        bus_read_done,
    output logic                        bus_write_done,
    periph_bus_if.sequencer             ram_bus,
    periph_bus_if.sequencer             regs_bus
);

    typedef enum logic {ST_IDLE, ST_WAIT} state_e;

    state_e                      state;
    periph_pkg::region_e         region, region_q;
    logic [periph_pkg::XLEN-1:0] offset, offset_q;
    logic [periph_pkg::XLEN-1:0] wdata_q;
    periph_pkg::ls_type_e        type_q;
    logic                        write_q;
    logic                        issue_q;   // request strobe to the target
    logic                        tgt_ack;
    logic [periph_pkg::XLEN-1:0] tgt_rdata;
    logic                        start;

    assign start = state == ST_IDLE && (bus_read_enable || bus_write_enable);

    // address decode
    always_comb begin
        region = periph_pkg::REG_NONE;
        offset = bus_address;
        if (bus_address >= periph_pkg::RAM_BASE &&
            bus_address < periph_pkg::RAM_BASE + periph_pkg::RAM_BYTES) begin
            region = periph_pkg::REG_RAM;
            offset = bus_address - periph_pkg::RAM_BASE;
        end else if (bus_address == periph_pkg::MTIMECMP_ADDR) begin
            region = periph_pkg::REG_MTIMECMP;
            offset = periph_pkg::XLEN'(periph_pkg::PLIC_SPAN); // just above the plic window
        end else if (bus_address >= periph_pkg::PLIC_BASE &&
                     bus_address < periph_pkg::PLIC_BASE + 64'(periph_pkg::PLIC_SPAN)) begin
            region = periph_pkg::REG_PLIC;
            offset = bus_address - periph_pkg::PLIC_BASE;
        end
    end

    // both targets share the latched request, only the strobe is steered
    assign ram_bus.req_valid    = issue_q && region_q == periph_pkg::REG_RAM;
    assign ram_bus.req_write    = write_q;
    assign ram_bus.req_ls_type  = type_q;
    assign ram_bus.req_offset   = offset_q;
    assign ram_bus.req_wdata    = wdata_q;
    assign regs_bus.req_valid   = issue_q && region_q != periph_pkg::REG_RAM
                                  && region_q != periph_pkg::REG_NONE;
    assign regs_bus.req_write   = write_q;
    assign regs_bus.req_ls_type = type_q;
    assign regs_bus.req_offset  = offset_q;
    assign regs_bus.req_wdata   = wdata_q;

    always_comb begin
        case (region_q)
            periph_pkg::REG_RAM: begin
                tgt_ack   = ram_bus.ack;
                tgt_rdata = ram_bus.rdata;
            end
            periph_pkg::REG_NONE: begin
                tgt_ack   = 1'b1; // unmapped, completes at once and reads zero
                tgt_rdata = '0;
            end
            default: begin
                tgt_ack   = regs_bus.ack;
                tgt_rdata = regs_bus.rdata;
            end
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state          <= ST_IDLE;
            region_q       <= periph_pkg::REG_NONE;
            write_q        <= 1'b0;
            issue_q        <= 1'b0;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            bus_read_data  <= '0;
        end else begin
            issue_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state    <= ST_WAIT;
                        region_q <= region;
                        write_q  <= bus_write_enable;
                        issue_q  <= region != periph_pkg::REG_NONE;
                        if (bus_read_enable) bus_read_done <= 1'b0;
                        if (bus_write_enable) bus_write_done <= 1'b0;
                    end
                end
                ST_WAIT: begin
                    if (tgt_ack) begin
                        state          <= ST_IDLE;
                        bus_read_done  <= 1'b1;
                        bus_write_done <= 1'b1;
                        if (!write_q) bus_read_data <= tgt_rdata;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request payload
    always_ff @(posedge CLOCK_50) begin
        if (start) begin
            offset_q <= offset;
            type_q   <= bus_ls_type;
            wdata_q  <= bus_write_data;
        end
    end

    // core must wait for both done flags before the next access
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (bus_read_enable || bus_write_enable) |-> (bus_read_done && bus_write_done));

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(bus_read_enable && bus_write_enable));

endmodule

// File: design/word_ram.sv
`timescale 1ns/1ps

module word_ram (
    input  logic         CLOCK_50,
    input  logic         KEY0,
    periph_bus_if.target bus
);

    logic [31:0] mem [periph_pkg::RAM_WORDS];

    logic [periph_pkg::RAM_AW-1:0] base_idx, idx;
    logic [1:0]                    lane;
    logic [3:0]                    be;      // byte lanes of the store
    logic [31:0]                   wword;
    logic                          beat;    // second word of a double pending
    logic                          access;
    logic                          ack_q;
    logic [periph_pkg::XLEN-1:0]   rdata_q;
    logic                          aligned;

    function automatic logic [63:0] load_extend(input logic [31:0] word,
                                                input logic [1:0] sel,
                                                input periph_pkg::ls_type_e t);
        logic [31:0] sh;
        sh = word >> (8 * sel);
        case (t)
            periph_pkg::LS_B:  return {{56{sh[7]}}, sh[7:0]};
            periph_pkg::LS_H:  return {{48{sh[15]}}, sh[15:0]};
            periph_pkg::LS_W:  return {{32{sh[31]}}, sh};
            periph_pkg::LS_BU: return {56'd0, sh[7:0]};
            periph_pkg::LS_HU: return {48'd0, sh[15:0]};
            default:           return {32'd0, sh}; // lwu and low half of ld
        endcase
    endfunction

    assign base_idx = bus.req_offset[periph_pkg::RAM_AW+1:2];
    assign idx      = beat ? base_idx + 1'b1 : base_idx;
    assign lane     = beat ? 2'd0 : bus.req_offset[1:0];
    assign access   = bus.req_valid || beat;
    assign wword    = beat ? bus.req_wdata[63:32] : bus.req_wdata[31:0] << (8 * lane);

    always_comb begin
        case (bus.req_ls_type)
            periph_pkg::LS_B: be = 4'b0001 << lane;
            periph_pkg::LS_H: be = 4'b0011 << lane;
            default:          be = 4'b1111;
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (access) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.req_write && be[i]) mem[idx][8*i +: 8] <= wword[8*i +: 8];
            end
            if (!bus.req_write) begin
                if (beat) rdata_q[63:32] <= mem[idx];
                else rdata_q <= load_extend(mem[idx], lane, bus.req_ls_type);
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat  <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (beat) begin
                beat  <= 1'b0;
                ack_q <= 1'b1;
            end else if (bus.req_valid) begin
                if (bus.req_ls_type == periph_pkg::LS_D) beat <= 1'b1;
                else ack_q <= 1'b1;
            end
        end
    end

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;

    always_comb begin
        case (bus.req_ls_type)
            periph_pkg::LS_B, periph_pkg::LS_BU: aligned = 1'b1;
            periph_pkg::LS_H, periph_pkg::LS_HU: aligned = !bus.req_offset[0];
            periph_pkg::LS_W, periph_pkg::LS_WU: aligned = bus.req_offset[1:0] == 2'd0;
            default:                             aligned = bus.req_offset[2:0] == 3'd0;
        endcase
    end

    // misaligned accesses are not supported by the core side
    assert property (@(posedge CLOCK_50) disable iff (!KEY0) bus.req_valid |-> aligned);

endmodule

// File: design/interrupt_regs.sv
`timescale 1ns/1ps

module interrupt_regs (
    input  logic                                CLOCK_50,
    input  logic                                KEY0,
    input  logic [periph_pkg::IRQ_SOURCES-2:0]  irq_lines, // bit i is id i+1
    output logic                                meip,
    output logic                                seip,
    output logic [periph_pkg::XLEN-1:0]         mtimecmp,
    periph_bus_if.target                        bus
);

    logic [periph_pkg::PRIO_W-1:0]      prio [periph_pkg::IRQ_SOURCES];
    logic [periph_pkg::IRQ_SOURCES-1:0] pending;
    logic [periph_pkg::IRQ_SOURCES-1:0] enable [2];
    logic [periph_pkg::PRIO_W-1:0]      threshold [2];
    logic [periph_pkg::IRQ_ID_W-1:0]    claim [2];
    logic [periph_pkg::IRQ_SOURCES-2:0] irq_q;
    logic [periph_pkg::IRQ_ID_W-1:0]    id;
    logic                               hit_prio, hit_pend, hit_mtc;
    logic [1:0]                         hit_en, hit_thr, hit_claim;
    logic [periph_pkg::XLEN-1:0]        rd_word;
    logic [periph_pkg::XLEN-1:0]        rdata_q;
    logic                               ack_q;

    // lowest eligible id wins, scan from the top down
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            claim[c] = '0;
            for (int i = periph_pkg::IRQ_SOURCES - 1; i >= 1; i--) begin
                if (pending[i] && enable[c][i] && prio[i] > threshold[c])
                    claim[c] = periph_pkg::IRQ_ID_W'(i);
            end
        end
    end

    assign meip = claim[0] != '0;
    assign seip = claim[1] != '0;

    // offset decode within the plic window, mtimecmp sits at the span
    assign id       = bus.req_offset[2 +: periph_pkg::IRQ_ID_W];
    assign hit_mtc  = bus.req_offset == periph_pkg::XLEN'(periph_pkg::PLIC_SPAN);
    assign hit_prio = bus.req_offset < periph_pkg::XLEN'(periph_pkg::IRQ_SOURCES * 4);
    assign hit_pend = bus.req_offset == periph_pkg::XLEN'(periph_pkg::PLIC_PENDING_OFS);

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            hit_en[c]    = bus.req_offset == periph_pkg::XLEN'(periph_pkg::PLIC_ENABLE_OFS
                           + c * periph_pkg::PLIC_CTX_ENABLE_STRIDE);
            hit_thr[c]   = bus.req_offset == periph_pkg::XLEN'(periph_pkg::PLIC_THRESHOLD_OFS
                           + c * periph_pkg::PLIC_CTX_STRIDE);
            hit_claim[c] = bus.req_offset == periph_pkg::XLEN'(periph_pkg::PLIC_CLAIM_OFS
                           + c * periph_pkg::PLIC_CTX_STRIDE);
        end
    end

    always_comb begin
        rd_word = '0; // unknown offsets read zero
        if (hit_mtc) rd_word = mtimecmp;
        if (hit_prio) rd_word = periph_pkg::XLEN'(prio[id]);
        if (hit_pend) rd_word = periph_pkg::XLEN'(pending);
        for (int c = 0; c < 2; c++) begin
            if (hit_en[c]) rd_word = periph_pkg::XLEN'(enable[c]);
            if (hit_thr[c]) rd_word = periph_pkg::XLEN'(threshold[c]);
            if (hit_claim[c]) rd_word = periph_pkg::XLEN'(claim[c]);
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 0; i < periph_pkg::IRQ_SOURCES; i++) prio[i] <= '0;
            for (int c = 0; c < 2; c++) begin
                enable[c]    <= '0;
                threshold[c] <= '0;
            end
            pending  <= '0;
            irq_q    <= '0;
            ack_q    <= 1'b0;
            mtimecmp <= periph_pkg::MTIMECMP_RESET;
        end else begin
            irq_q <= irq_lines;
            ack_q <= bus.req_valid;
            if (bus.req_valid && bus.req_write) begin
                if (hit_prio && id != '0) prio[id] <= bus.req_wdata[periph_pkg::PRIO_W-1:0];
                if (hit_mtc) mtimecmp <= bus.req_wdata;
                for (int c = 0; c < 2; c++) begin
                    if (hit_en[c])
                        enable[c] <= {bus.req_wdata[periph_pkg::IRQ_SOURCES-1:1], 1'b0};
                    if (hit_thr[c]) threshold[c] <= bus.req_wdata[periph_pkg::PRIO_W-1:0];
                end
            end else if (bus.req_valid) begin
                for (int c = 0; c < 2; c++) begin
                    if (hit_claim[c]) pending[claim[c]] <= 1'b0; // claim read completes it
                end
            end
            // new edges after the claim clear so none is lost
            for (int i = 1; i < periph_pkg::IRQ_SOURCES; i++) begin
                if (irq_lines[i-1] && !irq_q[i-1]) pending[i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (bus.req_valid) rdata_q <= rd_word;
    end

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;

    // one request in flight, no new strobe while acking
    assert property (@(posedge CLOCK_50) disable iff (!KEY0) bus.ack |-> !bus.req_valid);

endmodule

// File: design/periph_bus_top.sv
`timescale 1ns/1ps

module periph_bus_top (
    input  logic                               CLOCK_50,
    input  logic                               KEY0,
    input  logic [periph_pkg::XLEN-1:0]        bus_address,
    input  logic [periph_pkg::XLEN-1:0]        bus_write_data,
    input  periph_pkg::ls_type_e               bus_ls_type,
    input  logic                               bus_read_enable,
    input  logic                               bus_write_enable,
    input  logic [periph_pkg::IRQ_SOURCES-2:0] irq_lines,
    output logic [periph_pkg::XLEN-1:0]        bus_read_data,
    output logic                               bus_read_done,
    output logic                               bus_write_done,
    output logic                               meip,
    output logic                               seip,
    output logic [periph_pkg::XLEN-1:0]        mtimecmp
);

    periph_bus_if ram_bus ();
    periph_bus_if regs_bus ();

    bus_sequencer u_sequencer (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .ram_bus          (ram_bus.sequencer),
        .regs_bus         (regs_bus.sequencer)
    );

    word_ram u_ram (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus      (ram_bus.target)
    );

    interrupt_regs u_regs (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .irq_lines (irq_lines),
        .meip      (meip),
        .seip      (seip),
        .mtimecmp  (mtimecmp),
        .bus       (regs_bus.target)
    );

endmodule

// File: tb/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic CLOCK_50,
    output logic KEY0
);

    localparam real HALF_PERIOD  = 20.0; // 40 ns period
    localparam int  RESET_CYCLES = 4;

    initial begin
        CLOCK_50 = 1'b0;
        forever #(HALF_PERIOD) CLOCK_50 = ~CLOCK_50;
    end

    initial begin
        KEY0 = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLOCK_50);
        @(negedge CLOCK_50); // release away from the active edge
        KEY0 = 1'b1;
    end

endmodule

// File: tb/periph_bus_tb.sv
`timescale 1ns/1ps

module periph_bus_tb;

    localparam int          MAX_CYCLES = 20000; // ~500 accesses at up to 6 cycles, plus margin
    localparam int          WIN_BYTES  = 256;   // random ram traffic stays in this window
    localparam logic [63:0] WIN_BASE   = periph_pkg::RAM_BASE + 64'h0F00;

    logic                 CLOCK_50, KEY0;
    logic [63:0]          bus_address, bus_write_data, bus_read_data, mtimecmp;
    periph_pkg::ls_type_e bus_ls_type;
    logic                 bus_read_enable, bus_write_enable;
    logic                 bus_read_done, bus_write_done, meip, seip;
    logic [4:0]           irq_lines;

    // reference models
    logic [7:0]  ram_m [WIN_BYTES];
    logic [2:0]  prio_m [periph_pkg::IRQ_SOURCES];
    logic [5:0]  pend_m;
    logic [5:0]  en_m [2];
    logic [2:0]  thr_m [2];
    logic [63:0] mtimecmp_m;
    logic [65:0] exp_q [$]; // {meip, seip, read data} per outstanding read
    logic        read_done_prev = 1'b1;
    int          cycles = 0;

    clock_gen u_clk (.CLOCK_50(CLOCK_50), .KEY0(KEY0));

    periph_bus_top DUT (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .irq_lines        (irq_lines),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .meip             (meip),
        .seip             (seip),
        .mtimecmp         (mtimecmp)
    );

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
        if (got !== want) begin
            $display("** Error: %s is %h, expected %h", name, got, want);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    function automatic int access_bytes(input periph_pkg::ls_type_e t);
        case (t)
            periph_pkg::LS_B, periph_pkg::LS_BU: return 1;
            periph_pkg::LS_H, periph_pkg::LS_HU: return 2;
            periph_pkg::LS_W, periph_pkg::LS_WU: return 4;
            default:                             return 8;
        endcase
    endfunction

    function automatic logic [63:0] enable_addr(input int ctx);
        return periph_pkg::PLIC_BASE + 64'(periph_pkg::PLIC_ENABLE_OFS)
               + 64'(ctx) * 64'(periph_pkg::PLIC_CTX_ENABLE_STRIDE);
    endfunction

    function automatic logic [63:0] thr_addr(input int ctx);
        return periph_pkg::PLIC_BASE + 64'(periph_pkg::PLIC_THRESHOLD_OFS)
               + 64'(ctx) * 64'(periph_pkg::PLIC_CTX_STRIDE);
    endfunction

    function automatic logic [63:0] claim_addr(input int ctx);
        return periph_pkg::PLIC_BASE + 64'(periph_pkg::PLIC_CLAIM_OFS)
               + 64'(ctx) * 64'(periph_pkg::PLIC_CTX_STRIDE);
    endfunction

    // lowest pending, enabled id whose priority beats the threshold
    function automatic int claim_of(input int ctx);
        for (int i = 1; i < periph_pkg::IRQ_SOURCES; i++) begin
            if (pend_m[i] && en_m[ctx][i] && prio_m[i] > thr_m[ctx]) return i;
        end
        return 0;
    endfunction

    function automatic logic [63:0] ram_load(input int ofs, input periph_pkg::ls_type_e t);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < access_bytes(t); i++) v[8*i +: 8] = ram_m[ofs + i]; // little endian
        case (t)
            periph_pkg::LS_B: v = {{56{v[7]}}, v[7:0]};
            periph_pkg::LS_H: v = {{48{v[15]}}, v[15:0]};
            periph_pkg::LS_W: v = {{32{v[31]}}, v[31:0]};
            default:          v = v;
        endcase
        return v;
    endfunction

    function automatic logic [63:0] ref_read(input logic [63:0] addr,
                                             input periph_pkg::ls_type_e t);
        logic [63:0] ofs;
        ofs = addr - periph_pkg::PLIC_BASE;
        if (addr >= WIN_BASE && addr < WIN_BASE + 64'(WIN_BYTES))
            return ram_load(int'(addr - WIN_BASE), t);
        if (addr == periph_pkg::MTIMECMP_ADDR) return mtimecmp_m;
        if (ofs < 64'(4 * periph_pkg::IRQ_SOURCES)) return 64'(prio_m[ofs[4:2]]);
        if (ofs == 64'(periph_pkg::PLIC_PENDING_OFS)) return 64'(pend_m);
        for (int c = 0; c < 2; c++) begin
            if (addr == enable_addr(c)) return 64'(en_m[c]);
            if (addr == thr_addr(c)) return 64'(thr_m[c]);
            if (addr == claim_addr(c)) return 64'(claim_of(c));
        end
        return '0; // unmapped reads zero
    endfunction

    task automatic model_write(input logic [63:0] addr, input logic [63:0] data,
                               input periph_pkg::ls_type_e t);
        logic [63:0] ofs;
        ofs = addr - periph_pkg::PLIC_BASE;
        if (addr >= WIN_BASE && addr < WIN_BASE + 64'(WIN_BYTES)) begin
            for (int i = 0; i < access_bytes(t); i++)
                ram_m[int'(addr - WIN_BASE) + i] = data[8*i +: 8];
        end
        if (addr == periph_pkg::MTIMECMP_ADDR) mtimecmp_m = data;
        if (ofs < 64'(4 * periph_pkg::IRQ_SOURCES) && ofs[4:2] != 3'd0)
            prio_m[ofs[4:2]] = data[2:0];
        for (int c = 0; c < 2; c++) begin
            if (addr == enable_addr(c)) en_m[c] = {data[5:1], 1'b0}; // id 0 never enabled
            if (addr == thr_addr(c)) thr_m[c] = data[2:0];
        end
    endtask

    task automatic bus_write(input logic [63:0] addr, input logic [63:0] data,
                             input periph_pkg::ls_type_e t);
        model_write(addr, data, t);
        @(negedge CLOCK_50);
        bus_address      = addr;
        bus_write_data   = data;
        bus_ls_type      = t;
        bus_write_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_write_enable = 1'b0;
        compare_value("bus_write_done", 64'(bus_write_done), 64'd0); // drops after the enable
        while (!bus_write_done) @(negedge CLOCK_50);
    endtask

    task automatic bus_read(input logic [63:0] addr, input periph_pkg::ls_type_e t);
        logic [63:0] want;
        int          id;
        want = ref_read(addr, t);
        for (int c = 0; c < 2; c++) begin
            if (addr == claim_addr(c)) begin
                id = claim_of(c);
                if (id != 0) pend_m[id] = 1'b0; // claimed id leaves pending
            end
        end
        exp_q.push_back({claim_of(0) != 0, claim_of(1) != 0, want});
        @(negedge CLOCK_50);
        bus_address     = addr;
        bus_ls_type     = t;
        bus_read_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_read_enable = 1'b0;
        compare_value("bus_read_done", 64'(bus_read_done), 64'd0); // drops after the enable
        while (!bus_read_done) @(negedge CLOCK_50);
    endtask

    task automatic pulse_irq(input logic [4:0] lines);
        @(negedge CLOCK_50);
        for (int i = 1; i < periph_pkg::IRQ_SOURCES; i++) begin
            if (lines[i-1]) pend_m[i] = 1'b1;
        end
        irq_lines = lines;
        repeat (2) @(negedge CLOCK_50);
        irq_lines = '0;
    endtask

    // context 1 first, its ids are also enabled in context 0
    task automatic drain_claims();
        for (int c = 1; c >= 0; c--) begin
            while (claim_of(c) != 0) bus_read(claim_addr(c), periph_pkg::LS_W);
            bus_read(claim_addr(c), periph_pkg::LS_W); // nothing left, reads 0
        end
    endtask

    // every completed read is checked, with the interrupt levels at that point
    always @(negedge CLOCK_50) begin : compare_reads
        logic [65:0] e;
        logic        rise;
        rise           = KEY0 && bus_read_done && !read_done_prev;
        read_done_prev = bus_read_done;
        if (rise && exp_q.size() == 0) begin
            $display("a read completed while no read was outstanding");
            $display("TB FAILED");
            $fatal(1);
        end else if (rise) begin
            e = exp_q.pop_front();
            compare_value("bus_read_data", bus_read_data, e[63:0]);
            compare_value("meip", 64'(meip), 64'(e[65]));
            compare_value("seip", 64'(seip), 64'(e[64]));
        end
    end

    always @(posedge CLOCK_50) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("run timed out after %0d clock cycles", cycles);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    initial begin : stimulus
        logic [63:0]          a;
        logic [63:0]          d;
        periph_pkg::ls_type_e t;
        logic                 wr;
        int                   o;
        void'($urandom(32'hd54f_4678));
        bus_address      = '0;
        bus_write_data   = '0;
        bus_ls_type      = periph_pkg::LS_W;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        irq_lines        = '0;
        pend_m           = '0;
        mtimecmp_m       = periph_pkg::MTIMECMP_RESET;
        for (int i = 0; i < periph_pkg::IRQ_SOURCES; i++) prio_m[i] = '0;
        for (int c = 0; c < 2; c++) begin
            en_m[c]  = '0;
            thr_m[c] = '0;
        end
        @(posedge KEY0);
        @(negedge CLOCK_50);

        compare_value("bus_read_done", 64'(bus_read_done), 64'd1);
        compare_value("bus_write_done", 64'(bus_write_done), 64'd1);
        compare_value("bus_read_data", bus_read_data, 64'd0);
        compare_value("meip", 64'(meip), 64'd0);
        compare_value("seip", 64'(seip), 64'd0);
        bus_read(periph_pkg::MTIMECMP_ADDR, periph_pkg::LS_D);

        // fill the window first so no load sees unwritten ram
        for (int i = 0; i < WIN_BYTES; i += 8) begin
            a = WIN_BASE + 64'(i);
            bus_write(a, a * 64'h9e37_79b9_7f4a_7c15, periph_pkg::LS_D);
        end
        for (int k = 0; k < 400; k++) begin
            t  = periph_pkg::ls_type_e'(3'($urandom_range(6, 0)));
            wr = 1'($urandom_range(1, 0));
            if (wr && t >= periph_pkg::LS_BU) t = periph_pkg::ls_type_e'(t - 3'd4);
            o  = int'($urandom_range(WIN_BYTES - 1, 0)) & ~(access_bytes(t) - 1);
            a  = WIN_BASE + 64'(o);
            d  = {$urandom, $urandom};
            if (wr) bus_write(a, d, t);
            else bus_read(a, t);
        end
        for (int i = 0; i < WIN_BYTES; i += 8) bus_read(WIN_BASE + 64'(i), periph_pkg::LS_D);

        d = {$urandom, $urandom};
        bus_write(periph_pkg::MTIMECMP_ADDR, d, periph_pkg::LS_D);
        bus_read(periph_pkg::MTIMECMP_ADDR, periph_pkg::LS_D);
        compare_value("mtimecmp", mtimecmp, d);

        // plic setup, ctx 0 threshold 2, ctx 1 sees only ids 2 and 3
        for (int id = 1; id < periph_pkg::IRQ_SOURCES; id++)
            bus_write(periph_pkg::PLIC_BASE + 64'(4 * id), 64'((id * 5 + 1) % 8), periph_pkg::LS_W);
        for (int id = 0; id < periph_pkg::IRQ_SOURCES; id++)
            bus_read(periph_pkg::PLIC_BASE + 64'(4 * id), periph_pkg::LS_W);
        bus_write(enable_addr(0), 64'h3e, periph_pkg::LS_W);
        bus_write(enable_addr(1), 64'h0c, periph_pkg::LS_W);
        bus_write(thr_addr(0), 64'd2, periph_pkg::LS_W);
        bus_write(thr_addr(1), 64'd0, periph_pkg::LS_W);
        for (int c = 0; c < 2; c++) begin
            bus_read(enable_addr(c), periph_pkg::LS_W);
            bus_read(thr_addr(c), periph_pkg::LS_W);
        end

        pulse_irq(5'b10101);
        bus_read(periph_pkg::PLIC_BASE + 64'(periph_pkg::PLIC_PENDING_OFS), periph_pkg::LS_W);
        drain_claims();
        pulse_irq(5'b01010);
        bus_read(periph_pkg::PLIC_BASE + 64'(periph_pkg::PLIC_PENDING_OFS), periph_pkg::LS_W);
        drain_claims();

        // unmapped space
        bus_write(64'h1000_0000, d, periph_pkg::LS_D);
        bus_read(64'h1000_0000, periph_pkg::LS_D);
        bus_read(periph_pkg::RAM_BASE + periph_pkg::RAM_BYTES, periph_pkg::LS_W);

        repeat (2) @(negedge CLOCK_50); // let the last compare run
        if (exp_q.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("%0d reads never completed", exp_q.size());
            $display("TB FAILED");
            $fatal(1);
        end
    end

endmodule

// File: periph_bus_top.f
design/periph_pkg.sv
design/periph_bus_if.sv
design/bus_sequencer.sv
design/word_ram.sv
design/interrupt_regs.sv
design/periph_bus_top.sv
tb/clock_gen.sv
tb/periph_bus_tb.sv

// File: Makefile
# Verilator simulation of the peripheral bus testbench

VERILATOR ?= verilator
TOP       ?= periph_bus_tb
FILELIST  ?= periph_bus_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
